//--- source/bridge_cfg_pkg.sv
package bridge_cfg_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 4;
    localparam int strb_w = 4;
    localparam int size_w = 3;    // load size code, same width as arsize

    // cache line geometry
    localparam int line_words = 4;
    localparam int line_w     = 128;
    localparam int beat_w     = 2;     // counts beats within one line
    localparam int line_off_w = 4;     // byte offset bits inside a line

    // fixed burst fields
    localparam logic [len_w-1:0]  fill_arlen = 4'd3;   // 4 beats
    localparam logic [len_w-1:0]  unc_arlen  = 4'd0;
    localparam logic [size_w-1:0] word_size  = 3'd2;   // 4 bytes per beat

    // transaction ids, one per engine
    localparam logic [id_w-1:0] id_fill = 4'd0;
    localparam logic [id_w-1:0] id_unc  = 4'd1;

endpackage

//--- source/bridge_types_pkg.sv
package bridge_types_pkg;

    typedef enum logic [1:0] {
        fs_idle,
        fs_addr,
        fs_data,
        fs_done
    } fill_state_e;

    typedef enum logic [2:0] {
        us_idle,
        us_rd_addr,
        us_rd_data,
        us_wr_send,
        us_wr_resp,
        us_done
    } unc_state_e;

    // who currently holds the AR channel
    typedef enum logic {
        own_fill,
        own_unc
    } ar_owner_e;

endpackage

//--- source/axi_rd_if.sv
`timescale 1ns/1ps

interface axi_rd_if;

    logic                              arvalid;
    logic                              arready;
    logic [bridge_cfg_pkg::addr_w-1:0] araddr;
    logic [bridge_cfg_pkg::len_w-1:0]  arlen;
    logic [bridge_cfg_pkg::size_w-1:0] arsize;
    logic                              rvalid;
    logic [bridge_cfg_pkg::data_w-1:0] rdata;
    logic                              rlast;
    logic                              rready;

    modport engine (
        output arvalid, araddr, arlen, arsize, rready,
        input  arready, rvalid, rdata, rlast
    );

    // arbiter side sees the request and returns routed beats
    modport arbiter (
        input  arvalid, araddr, arlen, arsize, rready,
        output arready, rvalid, rdata, rlast
    );

endinterface

//--- source/line_fill_ctrl.sv
`timescale 1ns/1ps

module line_fill_ctrl (
    input  logic                              aclk,
    input  logic                              rst,
    input  logic                              fill_req,
    input  logic [bridge_cfg_pkg::addr_w-1:0] fill_addr,
    output logic                              fill_rdy,
    output logic                              fill_ret_valid,
    output logic [bridge_cfg_pkg::line_w-1:0] fill_ret_data,
    axi_rd_if.engine                          rd
);

    bridge_types_pkg::fill_state_e     state;
    logic [bridge_cfg_pkg::addr_w-1:0] line_addr;
    logic [bridge_cfg_pkg::beat_w-1:0] beat_cnt;
    logic [bridge_cfg_pkg::line_w-1:0] line_q;
    logic                              accept;

    // done doubles as idle so a new fill can start right away
    assign fill_rdy = (state == bridge_types_pkg::fs_idle) ||
                      (state == bridge_types_pkg::fs_done);
    assign accept         = fill_req && fill_rdy;
    assign fill_ret_valid = (state == bridge_types_pkg::fs_done);
    assign fill_ret_data  = line_q;

    assign rd.arvalid = (state == bridge_types_pkg::fs_addr);
    assign rd.araddr  = line_addr;
    assign rd.arlen   = bridge_cfg_pkg::fill_arlen;
    assign rd.arsize  = bridge_cfg_pkg::word_size;
    assign rd.rready  = (state == bridge_types_pkg::fs_data);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= bridge_types_pkg::fs_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                bridge_types_pkg::fs_idle,
                bridge_types_pkg::fs_done: begin
                    if (accept)
                        state <= bridge_types_pkg::fs_addr;
                    else
                        state <= bridge_types_pkg::fs_idle;
                end
                bridge_types_pkg::fs_addr: begin
                    if (rd.arready) begin
                        state    <= bridge_types_pkg::fs_data;
                        beat_cnt <= '0;
                    end
                end
                bridge_types_pkg::fs_data: begin
                    if (rd.rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rd.rlast)
                            state <= bridge_types_pkg::fs_done;
                    end
                end
                default: state <= bridge_types_pkg::fs_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept)
            line_addr <= {fill_addr[bridge_cfg_pkg::addr_w-1:bridge_cfg_pkg::line_off_w],
                          {bridge_cfg_pkg::line_off_w{1'b0}}};  // 16-byte aligned
        if (rd.rvalid && rd.rready)
            line_q[beat_cnt*bridge_cfg_pkg::data_w +: bridge_cfg_pkg::data_w] <= rd.rdata;
    end

    // slave must not see the request change before it takes it
    assert property (@(posedge aclk) disable iff (rst)
        rd.arvalid && !rd.arready |=> rd.arvalid && $stable(rd.araddr))
        else $error("fill AR withdrawn before arready");

    // burst length from the slave has to match the line
    assert property (@(posedge aclk) disable iff (rst)
        rd.rvalid && rd.rready |-> rd.rlast == (beat_cnt == bridge_cfg_pkg::line_words - 1))
        else $error("fill rlast not on fourth beat");

endmodule

//--- source/uncached_ctrl.sv
`timescale 1ns/1ps

module uncached_ctrl (
    input  logic                              aclk,
    input  logic                              rst,
    input  logic                              unc_rd_req,
    input  logic [bridge_cfg_pkg::addr_w-1:0] unc_rd_addr,
    input  logic [bridge_cfg_pkg::size_w-1:0] unc_load_size,
    output logic                              unc_rd_rdy,
    output logic                              unc_ret_valid,
    output logic [bridge_cfg_pkg::data_w-1:0] unc_ret_data,
    input  logic                              unc_wr_req,
    input  logic [bridge_cfg_pkg::addr_w-1:0] unc_wr_addr,
    input  logic [bridge_cfg_pkg::strb_w-1:0] unc_wr_strb,
    input  logic [bridge_cfg_pkg::data_w-1:0] unc_wr_data,
    output logic                              unc_wr_rdy,
    output logic                              unc_wr_valid,
    axi_rd_if.engine                          rd,
    output logic [bridge_cfg_pkg::addr_w-1:0] awaddr,
    output logic [bridge_cfg_pkg::size_w-1:0] awsize,
    output logic                              awvalid,
    input  logic                              awready,
    output logic [bridge_cfg_pkg::data_w-1:0] wdata,
    output logic [bridge_cfg_pkg::strb_w-1:0] wstrb,
    output logic                              wvalid,
    input  logic                              wready,
    input  logic                              bvalid,
    output logic                              bready
);

    bridge_types_pkg::unc_state_e      state;
    logic                              is_wr;
    logic [bridge_cfg_pkg::addr_w-1:0] addr_q;
    logic [bridge_cfg_pkg::size_w-1:0] size_q;
    logic [bridge_cfg_pkg::data_w-1:0] rdata_q;
    logic                              free;
    logic                              rd_accept;
    logic                              wr_accept;
    logic                              aw_ok;
    logic                              w_ok;

    assign free = (state == bridge_types_pkg::us_idle) ||
                  (state == bridge_types_pkg::us_done);
    assign unc_rd_rdy = free;
    assign unc_wr_rdy = free;
    assign rd_accept  = unc_rd_req && free;
    assign wr_accept  = unc_wr_req && free && !unc_rd_req;   // read wins

    assign unc_ret_valid = (state == bridge_types_pkg::us_done) && !is_wr;
    assign unc_wr_valid  = (state == bridge_types_pkg::us_done) && is_wr;
    assign unc_ret_data  = rdata_q;

    assign rd.arvalid = (state == bridge_types_pkg::us_rd_addr);
    assign rd.araddr  = addr_q;
    assign rd.arlen   = bridge_cfg_pkg::unc_arlen;
    assign rd.arsize  = size_q;
    assign rd.rready  = (state == bridge_types_pkg::us_rd_data);

    assign awaddr = addr_q;
    assign awsize = bridge_cfg_pkg::word_size;
    assign bready = (state == bridge_types_pkg::us_wr_resp);

    // channel finished or finishing this cycle
    assign aw_ok = !awvalid || awready;
    assign w_ok  = !wvalid || wready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= bridge_types_pkg::us_idle;
            is_wr   <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            if (wr_accept) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (awready)
                    awvalid <= 1'b0;
                if (wready)
                    wvalid <= 1'b0;
            end

            case (state)
                bridge_types_pkg::us_idle,
                bridge_types_pkg::us_done: begin
                    if (rd_accept) begin
                        state <= bridge_types_pkg::us_rd_addr;
                        is_wr <= 1'b0;
                    end else if (wr_accept) begin
                        state <= bridge_types_pkg::us_wr_send;
                        is_wr <= 1'b1;
                    end else begin
                        state <= bridge_types_pkg::us_idle;
                    end
                end
                bridge_types_pkg::us_rd_addr:
                    if (rd.arready) state <= bridge_types_pkg::us_rd_data;
                bridge_types_pkg::us_rd_data:
                    if (rd.rvalid) state <= bridge_types_pkg::us_done;
                bridge_types_pkg::us_wr_send:
                    if (aw_ok && w_ok) state <= bridge_types_pkg::us_wr_resp;
                bridge_types_pkg::us_wr_resp:
                    if (bvalid) state <= bridge_types_pkg::us_done;
                default: state <= bridge_types_pkg::us_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_accept) begin
            addr_q <= unc_rd_addr;
            size_q <= unc_load_size;
        end else if (wr_accept) begin
            addr_q <= unc_wr_addr;
            wdata  <= unc_wr_data;
            wstrb  <= unc_wr_strb;
        end
        if (rd.rvalid && rd.rready)
            rdata_q <= rd.rdata;   // returned as is, no lane shifting
    end

    // leaving wr_send needs both channels done, so one valid stays up until then
    assert property (@(posedge aclk) disable iff (rst)
        state == bridge_types_pkg::us_wr_send |-> awvalid || wvalid)
        else $error("uncached write stalled with AW and W both idle");

endmodule

//--- source/ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter (
    input  logic                              aclk,
    input  logic                              rst,
    axi_rd_if.arbiter                         fill,
    axi_rd_if.arbiter                         unc,
    output logic [bridge_cfg_pkg::id_w-1:0]   arid,
    output logic [bridge_cfg_pkg::addr_w-1:0] araddr,
    output logic [bridge_cfg_pkg::len_w-1:0]  arlen,
    output logic [bridge_cfg_pkg::size_w-1:0] arsize,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [bridge_cfg_pkg::id_w-1:0]   rid,
    input  logic [bridge_cfg_pkg::data_w-1:0] rdata,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready
);

    bridge_types_pkg::ar_owner_e owner_q;
    bridge_types_pkg::ar_owner_e owner;
    logic                        locked;
    logic                        sel_unc;
    logic                        r_unc;

    // a pending grant is kept, otherwise uncached goes first
    assign owner = locked ? owner_q :
                   (unc.arvalid ? bridge_types_pkg::own_unc : bridge_types_pkg::own_fill);
    assign sel_unc = (owner == bridge_types_pkg::own_unc);

    assign arvalid = sel_unc ? unc.arvalid : fill.arvalid;
    assign araddr  = sel_unc ? unc.araddr  : fill.araddr;
    assign arlen   = sel_unc ? unc.arlen   : fill.arlen;
    assign arsize  = sel_unc ? unc.arsize  : fill.arsize;
    assign arid    = sel_unc ? bridge_cfg_pkg::id_unc : bridge_cfg_pkg::id_fill;

    assign unc.arready  = arready && sel_unc;
    assign fill.arready = arready && !sel_unc;

    always_ff @(posedge aclk) begin
        if (rst) begin
            locked  <= 1'b0;
            owner_q <= bridge_types_pkg::own_fill;
        end else if (arvalid && !arready) begin
            locked  <= 1'b1;   // slave stalled, hold the winner
            owner_q <= owner;
        end else if (arready) begin
            locked <= 1'b0;
        end
    end

    // R steering by id
    assign r_unc = (rid == bridge_cfg_pkg::id_unc);

    assign fill.rvalid = rvalid && (rid == bridge_cfg_pkg::id_fill);
    assign unc.rvalid  = rvalid && r_unc;
    assign fill.rdata  = rdata;
    assign unc.rdata   = rdata;
    assign fill.rlast  = rlast;
    assign unc.rlast   = rlast;
    assign rready      = r_unc ? unc.rready : fill.rready;

    // any other id would be silently dropped by the steering above
    assert property (@(posedge aclk) disable iff (rst)
        rvalid |-> rid == bridge_cfg_pkg::id_fill || rid == bridge_cfg_pkg::id_unc)
        else $error("R beat with unknown rid %0d", rid);

endmodule

//--- source/mem_bridge_top.sv
`timescale 1ns/1ps

module mem_bridge_top (
    input  logic                              aclk,
    input  logic                              rst,
    // line fill client
    input  logic                              fill_req,
    input  logic [bridge_cfg_pkg::addr_w-1:0] fill_addr,
    output logic                              fill_rdy,
    output logic                              fill_ret_valid,
    output logic [bridge_cfg_pkg::line_w-1:0] fill_ret_data,
    // uncached client
    input  logic                              unc_rd_req,
    input  logic [bridge_cfg_pkg::addr_w-1:0] unc_rd_addr,
    input  logic [bridge_cfg_pkg::size_w-1:0] unc_load_size,
    output logic                              unc_rd_rdy,
    output logic                              unc_ret_valid,
    output logic [bridge_cfg_pkg::data_w-1:0] unc_ret_data,
    input  logic                              unc_wr_req,
    input  logic [bridge_cfg_pkg::addr_w-1:0] unc_wr_addr,
    input  logic [bridge_cfg_pkg::strb_w-1:0] unc_wr_strb,
    input  logic [bridge_cfg_pkg::data_w-1:0] unc_wr_data,
    output logic                              unc_wr_rdy,
    output logic                              unc_wr_valid,
    // AXI read
    output logic [bridge_cfg_pkg::id_w-1:0]   arid,
    output logic [bridge_cfg_pkg::addr_w-1:0] araddr,
    output logic [bridge_cfg_pkg::len_w-1:0]  arlen,
    output logic [bridge_cfg_pkg::size_w-1:0] arsize,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [bridge_cfg_pkg::id_w-1:0]   rid,
    input  logic [bridge_cfg_pkg::data_w-1:0] rdata,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready,
    // AXI write
    output logic [bridge_cfg_pkg::addr_w-1:0] awaddr,
    output logic [bridge_cfg_pkg::size_w-1:0] awsize,
    output logic                              awvalid,
    input  logic                              awready,
    output logic [bridge_cfg_pkg::data_w-1:0] wdata,
    output logic [bridge_cfg_pkg::strb_w-1:0] wstrb,
    output logic                              wvalid,
    input  logic                              wready,
    input  logic                              bvalid,
    output logic                              bready
);

    axi_rd_if fill_rd ();
    axi_rd_if unc_rd ();

    line_fill_ctrl u_line_fill (
        .aclk           (aclk),
        .rst            (rst),
        .fill_req       (fill_req),
        .fill_addr      (fill_addr),
        .fill_rdy       (fill_rdy),
        .fill_ret_valid (fill_ret_valid),
        .fill_ret_data  (fill_ret_data),
        .rd             (fill_rd)
    );

    uncached_ctrl u_uncached (
        .aclk (aclk), .rst (rst),
        .unc_rd_req (unc_rd_req), .unc_rd_addr (unc_rd_addr), .unc_load_size (unc_load_size),
        .unc_rd_rdy (unc_rd_rdy), .unc_ret_valid (unc_ret_valid), .unc_ret_data (unc_ret_data),
        .unc_wr_req (unc_wr_req), .unc_wr_addr (unc_wr_addr), .unc_wr_strb (unc_wr_strb),
        .unc_wr_data (unc_wr_data), .unc_wr_rdy (unc_wr_rdy), .unc_wr_valid (unc_wr_valid),
        .rd (unc_rd),
        .awaddr (awaddr), .awsize (awsize), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready)
    );

    ar_arbiter u_ar_arbiter (
        .aclk (aclk), .rst (rst),
        .fill (fill_rd), .unc (unc_rd),
        .arid (arid), .araddr (araddr), .arlen (arlen), .arsize (arsize),
        .arvalid (arvalid), .arready (arready),
        .rid (rid), .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready)
    );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int half_period = 5,
    parameter int rst_cycles  = 16
) (
    output logic aclk,
    output logic rst
);

    initial begin
        aclk = 1'b0;
        forever #(half_period) aclk = ~aclk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge aclk);
        #1 rst = 1'b0;   // released off the edge like the other inputs
    end

endmodule

//--- tb/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model #(
    parameter int seed_init = 62
) (
    input  logic                              aclk,
    input  logic                              rst,
    input  logic [bridge_cfg_pkg::id_w-1:0]   arid,
    input  logic [bridge_cfg_pkg::addr_w-1:0] araddr,
    input  logic [bridge_cfg_pkg::len_w-1:0]  arlen,
    input  logic [bridge_cfg_pkg::size_w-1:0] arsize,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [bridge_cfg_pkg::id_w-1:0]   rid,
    output logic [bridge_cfg_pkg::data_w-1:0] rdata,
    output logic                              rlast,
    output logic                              rvalid,
    input  logic                              rready,
    input  logic [bridge_cfg_pkg::addr_w-1:0] awaddr,
    input  logic [bridge_cfg_pkg::size_w-1:0] awsize,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [bridge_cfg_pkg::data_w-1:0] wdata,
    input  logic [bridge_cfg_pkg::strb_w-1:0] wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic                              bvalid,
    input  logic                              bready
);

    logic [31:0] mem [logic [31:0]];
    logic [32:0] rq_fill[$];   // {last, addr} per beat
    logic [32:0] rq_unc[$];
    logic [32:0] beat;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic        aw_have;
    logic        w_have;
    logic        b_pend;
    logic        ar_hs;
    logic        r_hs;
    logic        b_hs;
    logic        pick_unc;
    int          seed;
    int          r_wait;
    int          b_wait;
    int          k;

    // unwritten words read back as a pattern of their own address
    function automatic logic [31:0] read_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa))
            return mem[wa];
        return wa ^ 32'ha5a5a5a5;
    endfunction

    function automatic void write_word(input logic [31:0] a, input logic [3:0] strb,
                                       input logic [31:0] d);
        logic [31:0] w;
        int          b;
        w = read_word(a);
        for (b = 0; b < 4; b++)
            if (strb[b])
                w[b*8 +: 8] = d[b*8 +: 8];
        mem[{a[31:2], 2'b00}] = w;
    endfunction

    initial begin
        seed    = seed_init;
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        rlast   = 1'b0;
        bvalid  = 1'b0;
        aw_have = 1'b0;
        w_have  = 1'b0;
        b_pend  = 1'b0;
        r_wait  = 0;
        b_wait  = 0;
        forever begin
            @(posedge aclk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            b_hs  = bvalid && bready;
            if (!rst) begin
                if (ar_hs) begin
                    for (k = 0; k <= int'(arlen); k++) begin
                        beat = {k == int'(arlen), araddr + 32'(4 * k)};
                        if (arid == bridge_cfg_pkg::id_unc)
                            rq_unc.push_back(beat);
                        else
                            rq_fill.push_back(beat);
                    end
                end
                if (awvalid && awready) begin
                    aw_have   = 1'b1;
                    aw_addr_q = awaddr;
                end
                if (wvalid && wready) begin
                    w_have   = 1'b1;
                    w_data_q = wdata;
                    w_strb_q = wstrb;
                end
                if (r_hs) begin
                    if (rid == bridge_cfg_pkg::id_unc)
                        rq_unc.delete(0);
                    else
                        rq_fill.delete(0);
                end
            end
            #1;
            if (rst) begin
                arready = 1'b0;
                awready = 1'b0;
                wready  = 1'b0;
                rvalid  = 1'b0;
                rlast   = 1'b0;
                bvalid  = 1'b0;
                aw_have = 1'b0;
                w_have  = 1'b0;
                b_pend  = 1'b0;
                r_wait  = 0;
                rq_fill.delete();
                rq_unc.delete();
            end else begin
                arready = ($random(seed) & 3) != 0;   // ready three cycles in four
                awready = ($random(seed) & 1) != 0;
                wready  = ($random(seed) & 1) != 0;
                if (r_hs) begin
                    rvalid = 1'b0;
                    r_wait = $random(seed) & 3;
                end
                if (!rvalid) begin
                    if (r_wait > 0) begin
                        r_wait--;
                    end else if (rq_fill.size() + rq_unc.size() > 0) begin
                        // ids may interleave beat by beat
                        pick_unc = (rq_fill.size() == 0) ||
                                   (rq_unc.size() != 0 && ($random(seed) & 1) != 0);
                        beat   = pick_unc ? rq_unc[0] : rq_fill[0];
                        rid    = pick_unc ? bridge_cfg_pkg::id_unc : bridge_cfg_pkg::id_fill;
                        rdata  = read_word(beat[31:0]);
                        rlast  = beat[32];
                        rvalid = 1'b1;
                    end
                end
                if (b_hs)
                    bvalid = 1'b0;
                if (aw_have && w_have) begin
                    write_word(aw_addr_q, w_strb_q, w_data_q);
                    aw_have = 1'b0;
                    w_have  = 1'b0;
                    b_pend  = 1'b1;
                    b_wait  = $random(seed) & 3;
                end
                if (b_pend && !bvalid) begin
                    if (b_wait > 0) begin
                        b_wait--;
                    end else begin
                        bvalid = 1'b1;
                        b_pend = 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- tb/tb_mem_bridge.sv
`timescale 1ns/1ps

module tb_mem_bridge;

    localparam int n_directed = 5;
    localparam int n_rand     = 60;
    localparam int n_total    = n_directed + n_rand;

    logic                              aclk;
    logic                              rst;
    logic                              fill_req;
    logic [bridge_cfg_pkg::addr_w-1:0] fill_addr;
    logic                              fill_rdy;
    logic                              fill_ret_valid;
    logic [bridge_cfg_pkg::line_w-1:0] fill_ret_data;
    logic                              unc_rd_req;
    logic [bridge_cfg_pkg::addr_w-1:0] unc_rd_addr;
    logic [bridge_cfg_pkg::size_w-1:0] unc_load_size;
    logic                              unc_rd_rdy;
    logic                              unc_ret_valid;
    logic [bridge_cfg_pkg::data_w-1:0] unc_ret_data;
    logic                              unc_wr_req;
    logic [bridge_cfg_pkg::addr_w-1:0] unc_wr_addr;
    logic [bridge_cfg_pkg::strb_w-1:0] unc_wr_strb;
    logic [bridge_cfg_pkg::data_w-1:0] unc_wr_data;
    logic                              unc_wr_rdy;
    logic                              unc_wr_valid;
    logic [bridge_cfg_pkg::id_w-1:0]   arid;
    logic [bridge_cfg_pkg::addr_w-1:0] araddr;
    logic [bridge_cfg_pkg::len_w-1:0]  arlen;
    logic [bridge_cfg_pkg::size_w-1:0] arsize;
    logic                              arvalid;
    logic                              arready;
    logic [bridge_cfg_pkg::id_w-1:0]   rid;
    logic [bridge_cfg_pkg::data_w-1:0] rdata;
    logic                              rlast;
    logic                              rvalid;
    logic                              rready;
    logic [bridge_cfg_pkg::addr_w-1:0] awaddr;
    logic [bridge_cfg_pkg::size_w-1:0] awsize;
    logic                              awvalid;
    logic                              awready;
    logic [bridge_cfg_pkg::data_w-1:0] wdata;
    logic [bridge_cfg_pkg::strb_w-1:0] wstrb;
    logic                              wvalid;
    logic                              wready;
    logic                              bvalid;
    logic                              bready;

    logic [31:0]  model_mem [logic [31:0]];
    logic [127:0] fill_exp_q[$];
    logic [31:0]  fill_ar_q[$];
    logic [31:0]  unc_exp_q[$];
    logic [34:0]  unc_ar_q[$];   // {size, addr}
    logic [34:0]  unc_ar;
    int           seed;
    int           issued = 0;
    int           completed = 0;
    int           race_issued = 0;
    int           race_checked = 0;

    tb_clk_gen u_clk (.aclk(aclk), .rst(rst));

    axi_slave_model #(.seed_init(62)) u_slave (.*);

    mem_bridge_top DUT (.*);

    task automatic check_equal(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("Error: time %0t, %s expected %0h actual %0h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (model_mem.exists(wa))
            return model_mem[wa];
        return wa ^ 32'ha5a5a5a5;
    endfunction

    function automatic logic [127:0] model_line(input logic [31:0] a);
        logic [127:0] line;
        int           i;
        for (i = 0; i < 4; i++)
            line[i*32 +: 32] = model_word({a[31:4], 4'h0} + 32'(4 * i));
        return line;
    endfunction

    function automatic void model_write(input logic [31:0] a, input logic [3:0] strb,
                                        input logic [31:0] d);
        logic [31:0] w;
        int          b;
        w = model_word(a);
        for (b = 0; b < 4; b++)
            if (strb[b])
                w[b*8 +: 8] = d[b*8 +: 8];
        model_mem[{a[31:2], 2'b00}] = w;
    endfunction

    // inputs move 1 ns after each edge
    task automatic next_cycle();
        @(posedge aclk);
        #1;
        fill_req   = 1'b0;
        unc_rd_req = 1'b0;
        unc_wr_req = 1'b0;
    endtask

    task automatic issue_fill(input logic [31:0] a);
        fill_req  = 1'b1;
        fill_addr = a;
        fill_exp_q.push_back(model_line(a));
        fill_ar_q.push_back({a[31:4], 4'h0});
        issued++;
    endtask

    task automatic issue_unc_rd(input logic [31:0] a, input logic [2:0] size);
        unc_rd_req    = 1'b1;
        unc_rd_addr   = a;
        unc_load_size = size;
        unc_exp_q.push_back(model_word(a));
        unc_ar_q.push_back({size, a});
        issued++;
    endtask

    task automatic issue_unc_wr(input logic [31:0] a, input logic [3:0] strb,
                                input logic [31:0] d);
        unc_wr_req  = 1'b1;
        unc_wr_addr = a;
        unc_wr_strb = strb;
        unc_wr_data = d;
        model_write(a, strb, d);
        issued++;
    endtask

    task automatic wait_all_done();
        while (completed != issued)
            next_cycle();
    endtask

    // AR and AW fields and completions sampled on the edge
    always @(posedge aclk) begin
        if (!rst) begin
            if (arvalid && arready) begin
                if (race_checked < race_issued) begin
                    check_equal("arid after same-cycle requests", bridge_cfg_pkg::id_unc, arid);
                    race_checked++;
                end
                if (arid == bridge_cfg_pkg::id_fill) begin
                    check_equal("araddr", fill_ar_q.pop_front(), araddr);
                    check_equal("arlen", 3, arlen);
                    check_equal("arsize", 2, arsize);
                end else begin
                    check_equal("arid", bridge_cfg_pkg::id_unc, arid);
                    unc_ar = unc_ar_q.pop_front();
                    check_equal("araddr", unc_ar[31:0], araddr);
                    check_equal("arlen", 0, arlen);
                    check_equal("arsize", unc_ar[34:32], arsize);
                end
            end
            if (awvalid && awready)
                check_equal("awsize", 2, awsize);   // full word writes only
            if (fill_ret_valid) begin
                check_equal("fill_ret_data", fill_exp_q.pop_front(), fill_ret_data);
                completed++;
            end
            if (unc_ret_valid) begin
                check_equal("unc_ret_data", unc_exp_q.pop_front(), unc_ret_data);
                completed++;
            end
            if (unc_wr_valid)
                completed++;
        end
    end

    initial begin
        repeat (16 + 200 * n_total) @(posedge aclk);
        $display("Error: watchdog expired with %0d of %0d requests done", completed, n_total);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed          = 62;
        fill_req      = 1'b0;
        fill_addr     = '0;
        unc_rd_req    = 1'b0;
        unc_rd_addr   = '0;
        unc_load_size = '0;
        unc_wr_req    = 1'b0;
        unc_wr_addr   = '0;
        unc_wr_strb   = '0;
        unc_wr_data   = '0;
        @(negedge rst);
        next_cycle();

        check_equal("fill_rdy", 1, fill_rdy);
        check_equal("unc_rd_rdy", 1, unc_rd_rdy);
        check_equal("unc_wr_rdy", 1, unc_wr_rdy);
        check_equal("arvalid", 0, arvalid);
        check_equal("awvalid", 0, awvalid);
        check_equal("wvalid", 0, wvalid);
        check_equal("rready", 0, rready);
        check_equal("bready", 0, bready);
        check_equal("fill_ret_valid", 0, fill_ret_valid);
        check_equal("unc_ret_valid", 0, unc_ret_valid);
        check_equal("unc_wr_valid", 0, unc_wr_valid);

        issue_fill(32'h0001_0a5c);   // unaligned so the low nibble must drop
        wait_all_done();
        issue_unc_rd(32'h0002_0024, 3'd2);
        wait_all_done();
        issue_unc_rd(32'h0002_0031, 3'd0);
        wait_all_done();
        issue_unc_wr(32'h0002_0010, 4'b0101, 32'h1122_3344);
        wait_all_done();
        issue_unc_rd(32'h0002_0010, 3'd2);
        wait_all_done();

        // fills and uncached traffic kept in separate regions
        while (issued < n_total) begin
            next_cycle();
            if (issued < n_total && fill_rdy && ($random(seed) & 1) != 0)
                issue_fill(32'h0001_0000 | ($random(seed) & 32'h0000_0fff));
            if (issued < n_total && unc_rd_rdy && ($random(seed) & 1) != 0) begin
                if (($random(seed) & 1) != 0)
                    issue_unc_rd(32'h0002_0000 | ($random(seed) & 32'h3f),
                                 3'($unsigned($random(seed)) % 3));
                else
                    issue_unc_wr(32'h0002_0000 | ($random(seed) & 32'h3c),
                                 4'($random(seed)), $random(seed));
            end
            if (fill_req && unc_rd_req)
                race_issued++;
        end
        wait_all_done();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- list.f
source/bridge_cfg_pkg.sv
source/bridge_types_pkg.sv
source/axi_rd_if.sv
source/line_fill_ctrl.sv
source/uncached_ctrl.sv
source/ar_arbiter.sv
source/mem_bridge_top.sv
tb/tb_clk_gen.sv
tb/axi_slave_model.sv
tb/tb_mem_bridge.sv

//--- run.sh
#!/bin/sh
# build the bridge with its testbench, run it, then search the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_bridge \
    -f list.f -o sim_bridge &&
./obj_dir/sim_bridge | tee sim.log
grep -q "Simulation finished: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
